// ==== rtl/qr_data_pkg.sv ====
// **************************************************
// QR data types and fixed-point constants
// **************************************************
package qr_data_pkg;

  localparam int data_w   = 13;
  localparam int k_w      = 11;
  localparam logic signed [k_w-1:0] k_gain = 11'sd622; // ~0.6074 in Q1.10
  localparam int num_rows = 8;
  localparam int num_cols = 4;
  localparam int num_iter = 8;   // cordic micro-steps

  typedef logic signed [data_w-1:0] elem_t;

  typedef struct packed {
    elem_t col3;
    elem_t col2;
    elem_t col1;
    elem_t col0;
  } matrix_row_t;

  typedef logic [$clog2(num_rows)-1:0] row_idx_t;
  typedef logic [$clog2(num_cols)-1:0] col_idx_t;

  typedef struct packed {
    elem_t x;
    elem_t y;
  } xy_pair_t;

  typedef logic [num_iter-1:0] rot_signs_t; // one direction bit per step

endpackage

// ==== rtl/qr_ctrl_pkg.sv ====
// **************************************************
// QR control types
// **************************************************
package qr_ctrl_pkg;

  typedef enum logic [1:0] {
    IDLE,
    CAL,
    OUT
  } seq_state_e;

  typedef enum logic {
    VECTOR,
    ROTATE
  } cordic_mode_e;

  typedef struct packed {
    qr_data_pkg::row_idx_t row_x;  // upper row of the pair
    qr_data_pkg::row_idx_t row_y;  // row being zeroed
    qr_data_pkg::col_idx_t col;
  } pair_addr_t;

endpackage

// ==== rtl/row_loader.sv ====
// **************************************************
// Matrix row loader
// **************************************************
`timescale 1ns/1ns

module row_loader (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    valid,
  input  qr_data_pkg::matrix_row_t in,
  input  logic                    idle,
  output logic                    load_we,
  output qr_data_pkg::row_idx_t   load_row,
  output qr_data_pkg::matrix_row_t load_data,
  output logic                    load_done
);
  import qr_data_pkg::*;

  row_idx_t row_q;

  assign load_we   = valid && idle; // strobes outside IDLE are dropped
  assign load_row  = row_q;
  assign load_data = in;
  assign load_done = load_we && (row_q == '0);

  // rows arrive 7 first, down to 0
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_q <= row_idx_t'(num_rows - 1);
    end else if (load_done) begin
      row_q <= row_idx_t'(num_rows - 1);
    end else if (load_we) begin
      row_q <= row_q - 1'b1;
    end
  end

endmodule

// ==== rtl/matrix_store.sv ====
// **************************************************
// 8x4 matrix register file
// **************************************************
`timescale 1ns/1ns

module matrix_store (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     load_we,
  input  qr_data_pkg::row_idx_t    load_row,
  input  qr_data_pkg::matrix_row_t load_data,
  input  qr_ctrl_pkg::pair_addr_t  pair_addr,
  input  logic                     wb_we,
  input  qr_data_pkg::xy_pair_t    wb_data,
  input  qr_data_pkg::row_idx_t    unload_row,
  output qr_data_pkg::xy_pair_t    operand,
  output qr_data_pkg::matrix_row_t unload_data
);
  import qr_data_pkg::*;

  elem_t mem [num_rows][num_cols];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < num_rows; r++) begin
        for (int c = 0; c < num_cols; c++) begin
          mem[r][c] <= '0;
        end
      end
    end else if (load_we) begin
      mem[load_row][0] <= load_data.col0;
      mem[load_row][1] <= load_data.col1;
      mem[load_row][2] <= load_data.col2;
      mem[load_row][3] <= load_data.col3;
    end else if (wb_we) begin
      // cordic result goes back to both rows of the pair
      mem[pair_addr.row_x][pair_addr.col] <= wb_data.x;
      mem[pair_addr.row_y][pair_addr.col] <= wb_data.y;
    end
  end

  // operand read for the cordic
  always_comb begin
    operand.x = mem[pair_addr.row_x][pair_addr.col];
    operand.y = mem[pair_addr.row_y][pair_addr.col];
  end

  always_comb begin
    unload_data.col0 = mem[unload_row][0];
    unload_data.col1 = mem[unload_row][1];
    unload_data.col2 = mem[unload_row][2];
    unload_data.col3 = mem[unload_row][3];
  end

endmodule

// ==== rtl/qr_sequencer.sv ====
// **************************************************
// Givens rotation sequencer
// **************************************************
`timescale 1ns/1ns

module qr_sequencer (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      load_done,
  input  logic                      cordic_done,
  input  qr_data_pkg::rot_signs_t   signs_out,
  input  logic                      unload_done,
  output logic                      idle,
  output qr_ctrl_pkg::pair_addr_t   pair_addr,
  output qr_ctrl_pkg::cordic_mode_e mode,
  output logic                      cordic_start,
  output qr_data_pkg::rot_signs_t   signs_in,
  output logic                      wb_we,
  output logic                      unload_start
);
  import qr_data_pkg::*;
  import qr_ctrl_pkg::*;

  seq_state_e state_q;
  col_idx_t   col_q;      // column being zeroed
  col_idx_t   rot_col_q;  // column the current op works on
  row_idx_t   row_q;      // lower row of the pair
  row_idx_t   last_row;
  logic       op_busy_q;
  logic       last_rot;
  logic       last_pair;
  logic       last_col;
  rot_signs_t signs_q;

  assign last_row  = row_idx_t'(col_q) + row_idx_t'(1);
  assign last_rot  = rot_col_q == col_idx_t'(num_cols - 1);
  assign last_pair = row_q == last_row;
  assign last_col  = col_q == col_idx_t'(num_cols - 1);

  assign idle         = state_q == IDLE;
  assign mode         = (rot_col_q == col_q) ? VECTOR : ROTATE; // first op per pair vectors
  assign pair_addr    = '{row_x: row_q - 1'b1, row_y: row_q, col: rot_col_q};
  assign cordic_start = (state_q == CAL) && !op_busy_q;
  assign wb_we        = (state_q == CAL) && cordic_done;
  assign signs_in     = signs_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= IDLE;
      col_q        <= '0;
      rot_col_q    <= '0;
      row_q        <= row_idx_t'(num_rows - 1);
      op_busy_q    <= 1'b0;
      signs_q      <= '0;
      unload_start <= 1'b0;
    end else begin
      unload_start <= 1'b0;
      case (state_q)
        IDLE: begin
          if (load_done) begin
            state_q   <= CAL;
            col_q     <= '0;
            rot_col_q <= '0;
            row_q     <= row_idx_t'(num_rows - 1);
            op_busy_q <= 1'b0;
          end
        end
        CAL: begin
          if (cordic_start) op_busy_q <= 1'b1;
          if (cordic_done) begin
            op_busy_q <= 1'b0;
            if (mode == VECTOR) signs_q <= signs_out; // reused by the rotations
            if (!last_rot) begin
              rot_col_q <= rot_col_q + 1'b1;
            end else if (!last_pair) begin
              row_q     <= row_q - 1'b1;
              rot_col_q <= col_q;
            end else if (!last_col) begin
              col_q     <= col_q + 1'b1;
              rot_col_q <= col_q + 1'b1;
              row_q     <= row_idx_t'(num_rows - 1);
            end else begin
              state_q      <= OUT;
              unload_start <= 1'b1;
            end
          end
        end
        OUT: begin
          if (unload_done) state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

// ==== rtl/cordic_unit.sv ====
// **************************************************
// Folded CORDIC, two micro-steps per clock
// **************************************************
`timescale 1ns/1ns

module cordic_unit (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      cordic_start,
  input  qr_ctrl_pkg::cordic_mode_e mode,
  input  qr_data_pkg::xy_pair_t     operand,
  input  qr_data_pkg::rot_signs_t   signs_in,
  output qr_data_pkg::xy_pair_t     result,
  output qr_data_pkg::rot_signs_t   signs_out,
  output logic                      cordic_done
);
  import qr_data_pkg::*;
  import qr_ctrl_pkg::*;

  elem_t        x_q, y_q;
  cordic_mode_e mode_q;
  rot_signs_t   signs_q;
  logic         busy_q;
  logic [2:0]   cnt_q;   // step pair, then scaling
  logic         last_cyc;
  logic [$clog2(num_iter)-1:0] i0, i1;
  logic         d0, d1;
  xy_pair_t     s0, s1;
  logic signed [data_w+k_w-1:0] prod_x, prod_y;

  function automatic xy_pair_t micro_step(input elem_t x, input elem_t y,
                                          input logic [$clog2(num_iter)-1:0] i,
                                          input logic d);
    xy_pair_t r;
    if (!d) begin
      r.x = x + (y >>> i);
      r.y = y - (x >>> i);
    end else begin
      r.x = x - (y >>> i);
      r.y = y + (x >>> i);
    end
    return r;
  endfunction

  assign last_cyc = cnt_q == 3'(num_iter / 2);

  always_comb begin
    i0 = {cnt_q[1:0], 1'b0};
    i1 = {cnt_q[1:0], 1'b1};
    d0 = (mode_q == VECTOR) ? y_q[data_w-1] : signs_q[i0];
    s0 = micro_step(x_q, y_q, i0, d0);
    d1 = (mode_q == VECTOR) ? s0.y[data_w-1] : signs_q[i1];
    s1 = micro_step(s0.x, s0.y, i1, d1);
  end

  // gain correction by K
  assign prod_x   = x_q * k_gain;
  assign prod_y   = y_q * k_gain;
  assign result.x = {prod_x[data_w+k_w-1], prod_x[data_w+k_w-3:k_w-1]};
  assign result.y = {prod_y[data_w+k_w-1], prod_y[data_w+k_w-3:k_w-1]};

  assign signs_out   = signs_q;
  assign cordic_done = busy_q && last_cyc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (cordic_start) begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
    end else if (busy_q) begin
      if (last_cyc) busy_q <= 1'b0;
      else          cnt_q  <= cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (cordic_start) begin
      x_q     <= operand.x;
      y_q     <= operand.y;
      mode_q  <= mode;
      signs_q <= signs_in;
    end else if (busy_q && !last_cyc) begin
      x_q <= s1.x;
      y_q <= s1.y;
      if (mode_q == VECTOR) begin
        signs_q[i0] <= d0; // record directions
        signs_q[i1] <= d1;
      end
    end
  end

endmodule

// ==== rtl/row_unloader.sv ====
// **************************************************
// Result row unloader
// **************************************************
`timescale 1ns/1ns

module row_unloader (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     unload_start,
  input  qr_data_pkg::matrix_row_t unload_data,
  output qr_data_pkg::row_idx_t    unload_row,
  output logic                     unload_done,
  output logic                     out_valid,
  output qr_data_pkg::matrix_row_t out
);
  import qr_data_pkg::*;

  row_idx_t row_q;
  logic     run_q;
  logic     active;

  assign active      = unload_start || run_q;
  assign unload_row  = row_q;
  assign unload_done = active && (row_q == '0); // counter wraps this cycle

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_q     <= row_idx_t'(num_rows - 1);
      run_q     <= 1'b0;
      out_valid <= 1'b0;
      out       <= '0;
    end else if (active) begin
      out_valid <= 1'b1;
      out       <= unload_data;
      row_q     <= row_q - 1'b1;
      run_q     <= row_q != '0;
    end else begin
      out_valid <= 1'b0;
      out       <= '0;   // zero outside the burst
    end
  end

endmodule

// ==== rtl/qr_cordic_top.sv ====
// **************************************************
// QR decomposition with folded CORDIC
// **************************************************
`timescale 1ns/1ns

module qr_cordic_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     valid,
  input  qr_data_pkg::matrix_row_t in,
  output logic                     out_valid,
  output qr_data_pkg::matrix_row_t out
);
  import qr_data_pkg::*;
  import qr_ctrl_pkg::*;

  logic         idle;
  logic         load_we;
  row_idx_t     load_row;
  matrix_row_t  load_data;
  logic         load_done;
  pair_addr_t   pair_addr;
  cordic_mode_e mode;
  logic         cordic_start;
  logic         cordic_done;
  xy_pair_t     operand;
  xy_pair_t     result;
  rot_signs_t   signs_in, signs_out;
  logic         wb_we;
  logic         unload_start;
  logic         unload_done;
  row_idx_t     unload_row;
  matrix_row_t  unload_data;

  row_loader i_loader (
    .clk, .rst_n, .valid, .in, .idle,
    .load_we, .load_row, .load_data, .load_done
  );

  matrix_store i_store (
    .clk, .rst_n, .load_we, .load_row, .load_data,
    .pair_addr, .wb_we, .wb_data(result), .unload_row,
    .operand, .unload_data
  );

  qr_sequencer i_seq (
    .clk, .rst_n, .load_done, .cordic_done, .signs_out, .unload_done,
    .idle, .pair_addr, .mode, .cordic_start, .signs_in, .wb_we, .unload_start
  );

  cordic_unit i_cordic (
    .clk, .rst_n, .cordic_start, .mode, .operand, .signs_in,
    .result, .signs_out, .cordic_done
  );

  row_unloader i_unloader (
    .clk, .rst_n, .unload_start, .unload_data,
    .unload_row, .unload_done, .out_valid, .out
  );

endmodule

// ==== dv/clk_gen.sv ====
// **************************************************
// Clock and reset
// **************************************************
`timescale 1ns/1ns

module clk_gen (
  output logic clk,
  output logic rst_n
);
  localparam int half_period  = 20;  // 40 ns clock
  localparam int reset_cycles = 5;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #2 rst_n = 1'b1;   // released away from the edge
  end

endmodule

// ==== dv/qr_checker.sv ====
// **************************************************
// QR output checker and reference model
// **************************************************
`timescale 1ns/1ns

module qr_checker (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     valid,
  input  qr_data_pkg::matrix_row_t in,
  input  logic                     out_valid,
  input  qr_data_pkg::matrix_row_t out,
  output int                       err_count,
  output int                       mat_done
);
  import qr_data_pkg::*;

  typedef matrix_row_t [num_rows-1:0] mat_t;

  mat_t        cap;       // indexed by store row
  mat_t        exp_m;
  matrix_row_t exp_row;
  int          rows_in;
  int          word_idx;
  logic        busy;      // matrix loaded and output pending

  function automatic int wrap_elem(input int v);
    logic [31:0] b;
    b = v;
    return {{19{b[12]}}, b[12:0]};
  endfunction

  // keeps bit 23 and bits 21..10 of the 24-bit product
  function automatic int gain_scale(input int v);
    logic [31:0] p;
    p = v * int'(k_gain);
    return {{19{p[23]}}, p[23], p[21:10]};
  endfunction

  function automatic void cordic_op(input int x_in, input int y_in, input bit vectoring,
                                    input rot_signs_t dirs_in, output int x_out,
                                    output int y_out, output rot_signs_t dirs_out);
    int   x;
    int   y;
    int   xs;
    int   ys;
    logic d;
    x = x_in;
    y = y_in;
    dirs_out = dirs_in;
    for (int i = 0; i < num_iter; i++) begin
      d = vectoring ? (y < 0) : dirs_in[i];
      dirs_out[i] = d;
      xs = x >>> i;
      ys = y >>> i;
      if (!d) begin
        x = wrap_elem(x + ys);
        y = wrap_elem(y - xs);
      end else begin
        x = wrap_elem(x - ys);
        y = wrap_elem(y + xs);
      end
    end
    x_out = gain_scale(x);
    y_out = gain_scale(y);
  endfunction

  function automatic mat_t qr_reference(input mat_t m);
    int         a [num_rows][num_cols];
    int         xn;
    int         yn;
    rot_signs_t dirs;
    mat_t       res;
    for (int r = 0; r < num_rows; r++) begin
      a[r][0] = m[r].col0;
      a[r][1] = m[r].col1;
      a[r][2] = m[r].col2;
      a[r][3] = m[r].col3;
    end
    for (int c = 0; c < num_cols; c++) begin
      for (int r = num_rows - 1; r > c; r--) begin
        cordic_op(a[r-1][c], a[r][c], 1'b1, '0, xn, yn, dirs);
        a[r-1][c] = xn;
        a[r][c]   = yn;
        for (int cc = c + 1; cc < num_cols; cc++) begin
          cordic_op(a[r-1][cc], a[r][cc], 1'b0, dirs, xn, yn, dirs);
          a[r-1][cc] = xn;
          a[r][cc]   = yn;
        end
      end
    end
    for (int r = 0; r < num_rows; r++) begin
      res[r].col0 = elem_t'(a[r][0]);
      res[r].col1 = elem_t'(a[r][1]);
      res[r].col2 = elem_t'(a[r][2]);
      res[r].col3 = elem_t'(a[r][3]);
    end
    return res;
  endfunction

  // sampled mid-cycle
  always @(negedge clk) begin
    if (!rst_n) begin
      err_count = 0;
      mat_done  = 0;
      rows_in   = 0;
      word_idx  = 0;
      busy      = 1'b0;
    end else begin
      if (out_valid && !busy) begin
        err_count++;
        $display("output word seen at %0t with no matrix loaded", $time);
      end else if (out_valid) begin
        exp_row = exp_m[num_rows - 1 - word_idx];   // row 7 leaves first
        if (out != exp_row) begin
          err_count++;
          $display("ERR %0t: row %0d got %0d %0d %0d %0d, expected %0d %0d %0d %0d",
                   $time, num_rows - 1 - word_idx, out.col3, out.col2, out.col1,
                   out.col0, exp_row.col3, exp_row.col2, exp_row.col1, exp_row.col0);
        end
        word_idx++;
        if (word_idx == num_rows) begin
          busy     = 1'b0;
          word_idx = 0;
          mat_done++;
        end
      end else begin
        if (out != '0) begin
          err_count++;
          $display("ERR %0t: out is %h while out_valid is low", $time, out);
        end
        if (busy && word_idx != 0) begin
          err_count++;
          $display("out_valid dropped after %0d of %0d rows", word_idx, num_rows);
          busy     = 1'b0;
          word_idx = 0;
          mat_done++;
        end
      end
      // rows only count while no matrix is pending
      if (valid && !busy) begin
        cap[num_rows - 1 - rows_in] = in;
        rows_in++;
        if (rows_in == num_rows) begin
          exp_m   = qr_reference(cap);
          busy    = 1'b1;
          rows_in = 0;
        end
      end
    end
  end

endmodule

// ==== dv/tb_top.sv ====
// **************************************************
// QR CORDIC testbench
// **************************************************
`timescale 1ns/1ns

module tb_top;
  import qr_data_pkg::*;

  localparam int num_matrices = 16;
  localparam int cycle_limit  = 450 * num_matrices + 100;
  localparam int drive_delay  = 2;

  logic        clk;
  logic        rst_n;
  logic        valid;
  logic        out_valid;
  matrix_row_t in;
  matrix_row_t out;
  int          err_count;
  int          mat_done;
  int          cycles = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  logic [31:0] lcg_state = 32'd64909;
  matrix_row_t stim [num_rows];   // indexed by store row
  matrix_row_t junk;

  clk_gen i_clk_gen (.clk, .rst_n);

  qr_cordic_top i_dut (.clk, .rst_n, .valid, .in, .out_valid, .out);

  qr_checker i_checker (
    .clk, .rst_n, .valid, .in, .out_valid, .out, .err_count, .mat_done
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // elements in -lim..lim
  task automatic next_row(input int lim, output matrix_row_t row);
    elem_t e [num_cols];
    for (int c = 0; c < num_cols; c++) begin
      lcg_state = lcg_next(lcg_state);
      e[c] = elem_t'(int'(lcg_state[30:16]) % (2 * lim + 1) - lim);
    end
    row = '{col3: e[3], col2: e[2], col1: e[1], col0: e[0]};
  endtask

  task automatic step();
    @(posedge clk);
    #drive_delay;
  endtask

  task automatic send_rows(input int from, input int to);
    for (int r = from; r >= to; r--) begin
      valid = 1'b1;
      in    = stim[r];
      step();
    end
    valid = 1'b0;
    in    = '0;
  endtask

  task automatic wait_matrix(input int target);
    while (mat_done < target) step();
    step();   // one more cycle so a ninth word is caught
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (err_count != errs_before) begin
      tests_failed++;
      $display("test %s: %0d check errors", name, err_count - errs_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  task automatic run_random(input string name);
    int e0;
    int d0;
    e0 = err_count;
    d0 = mat_done;
    foreach (stim[r]) next_row(500, stim[r]);
    send_rows(num_rows - 1, 0);
    wait_matrix(d0 + 1);
    finish_test(name, e0);
  endtask

  initial begin
    int e0;
    int d0;
    valid = 1'b0;
    in    = '0;
    @(posedge rst_n);
    repeat (10) step();

    // diagonal matrix with row 0 held back while the output stays idle
    e0 = err_count;
    d0 = mat_done;
    foreach (stim[r]) stim[r] = '0;
    stim[0].col0 = 13'sd120;
    stim[1].col1 = -13'sd250;
    stim[2].col2 = 13'sd400;
    stim[3].col3 = 13'sd75;
    send_rows(num_rows - 1, 1);
    repeat (20) step();
    send_rows(0, 0);
    wait_matrix(d0 + 1);
    finish_test("diag_partial", e0);

    e0 = err_count;
    d0 = mat_done;
    foreach (stim[r]) stim[r] = '{col3: 13'sd17, col2: 13'sd333, col1: -13'sd150,
                                  col0: 13'sd200};
    send_rows(num_rows - 1, 0);
    wait_matrix(d0 + 1);
    finish_test("equal_cols", e0);

    for (int k = 0; k < 10; k++) run_random($sformatf("random_%0d", k));

    e0 = err_count;
    d0 = mat_done;
    foreach (stim[r]) next_row(500, stim[r]);
    send_rows(num_rows - 1, 0);
    wait_matrix(d0 + 1);
    foreach (stim[r]) next_row(500, stim[r]);
    send_rows(num_rows - 1, 0);
    wait_matrix(d0 + 2);
    finish_test("back_to_back", e0);

    // garbage strobes during CAL and during the output burst
    e0 = err_count;
    d0 = mat_done;
    foreach (stim[r]) next_row(500, stim[r]);
    send_rows(num_rows - 1, 0);
    repeat (15) begin
      next_row(4095, junk);
      valid = 1'b1;
      in    = junk;
      step();
      valid = 1'b0;
      step();
    end
    while (!out_valid) step();
    repeat (4) begin
      next_row(4095, junk);
      valid = 1'b1;
      in    = junk;
      step();
    end
    valid = 1'b0;
    in    = '0;
    wait_matrix(d0 + 1);
    // next matrix lands on the right rows only if no junk row was taken
    foreach (stim[r]) next_row(500, stim[r]);
    send_rows(num_rows - 1, 0);
    wait_matrix(d0 + 2);
    finish_test("garbage_valid", e0);

    repeat (5) step();
    $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

endmodule

// ==== files.f ====
rtl/qr_data_pkg.sv
rtl/qr_ctrl_pkg.sv
rtl/row_loader.sv
rtl/matrix_store.sv
rtl/qr_sequencer.sv
rtl/cordic_unit.sv
rtl/row_unloader.sv
rtl/qr_cordic_top.sv
dv/clk_gen.sv
dv/qr_checker.sv
dv/tb_top.sv

// ==== Makefile ====
BIN  = obj_dir/Vtb_top
SRCS = $(shell cat files.f)

all: run

$(BIN): files.f $(SRCS)
	verilator --binary --timing -Wno-fatal -f files.f --top-module tb_top -Mdir obj_dir

run: $(BIN)
	$(BIN) > sim.log 2>&1; cat sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
